//--- verilog/isa_pkg.sv
// ================================================
// RV32I base encodings only. CSR funct3 codes are
// left out, so those words decode as unknown ops
// ================================================

package isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] instr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [11:0]     sys_imm_t;

    // Major opcodes
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_fence  = 7'b0001111;
    localparam opcode_t op_system = 7'b1110011;

    // ALU ops, shared by register and immediate forms
    localparam funct3_t funct3_add  = 3'b000;
    localparam funct3_t funct3_sll  = 3'b001;
    localparam funct3_t funct3_slt  = 3'b010;
    localparam funct3_t funct3_sltu = 3'b011;
    localparam funct3_t funct3_xor  = 3'b100;
    localparam funct3_t funct3_srl  = 3'b101;
    localparam funct3_t funct3_or   = 3'b110;
    localparam funct3_t funct3_and  = 3'b111;

    localparam funct3_t funct3_lb  = 3'b000;
    localparam funct3_t funct3_lh  = 3'b001;
    localparam funct3_t funct3_lw  = 3'b010;
    localparam funct3_t funct3_lbu = 3'b100;
    localparam funct3_t funct3_lhu = 3'b101;

    localparam funct3_t funct3_sb = 3'b000;
    localparam funct3_t funct3_sh = 3'b001;
    localparam funct3_t funct3_sw = 3'b010;

    localparam funct3_t funct3_beq  = 3'b000;
    localparam funct3_t funct3_bne  = 3'b001;
    localparam funct3_t funct3_blt  = 3'b100;
    localparam funct3_t funct3_bge  = 3'b101;
    localparam funct3_t funct3_bltu = 3'b110;
    localparam funct3_t funct3_bgeu = 3'b111;

    localparam funct3_t funct3_fence   = 3'b000;
    localparam funct3_t funct3_fence_i = 3'b001;
    localparam funct3_t funct3_priv    = 3'b000;   // ECALL, EBREAK, MRET

    localparam sys_imm_t imm_ecall  = 12'h000;
    localparam sys_imm_t imm_ebreak = 12'h001;
    localparam sys_imm_t imm_mret   = 12'h302;

    localparam int alt_bit = 30;   // SUB, SRA, SRAI

endpackage

//--- verilog/ctrl_pkg.sv
// ================================================
// Datapath control encodings. Function codes are
// interpreted per ALU unit, so values repeat
// ================================================

package ctrl_pkg;

    typedef enum logic [1:0] {
        unit_adder = 2'd0,
        unit_logic = 2'd1,
        unit_shift = 2'd2,
        unit_cmp   = 2'd3
    } alu_unit_t;

    typedef logic [3:0] alu_func_t;

    typedef enum logic [1:0] {
        pc_sel_none = 2'd0,
        pc_sel_pc   = 2'd1,
        pc_sel_zero = 2'd2
    } pc_sel_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_ret = 2'd2    // PC + 4
    } wb_sel_t;

    typedef enum logic [3:0] {
        mask_none = 4'b0000,
        mask_byte = 4'b0001,
        mask_half = 4'b0011,
        mask_word = 4'b1111
    } byte_mask_t;

    localparam alu_func_t func_add  = 4'b0000;
    localparam alu_func_t func_sub  = 4'b1000;
    localparam alu_func_t func_srl  = 4'b0001;
    localparam alu_func_t func_sll  = 4'b0011;
    localparam alu_func_t func_sra  = 4'b0111;
    localparam alu_func_t func_slt  = 4'b0011;
    localparam alu_func_t func_sltu = 4'b0111;
    localparam alu_func_t func_xor  = 4'b0100;
    localparam alu_func_t func_or   = 4'b0110;
    localparam alu_func_t func_and  = 4'b0111;

    localparam alu_func_t func_beq  = 4'b0000;
    localparam alu_func_t func_bne  = 4'b0001;
    localparam alu_func_t func_bge  = 4'b0010;
    localparam alu_func_t func_blt  = 4'b0011;
    localparam alu_func_t func_bgeu = 4'b0110;
    localparam alu_func_t func_bltu = 4'b0111;

    typedef struct packed {
        logic       alu_imm_select;
        pc_sel_t    alu_pc_select;
        logic       alu_mux1_select;
        alu_unit_t  alu_unit;
        alu_func_t  alu_func;
        logic       rf_w_en;
        wb_sel_t    rf_w_select;
        byte_mask_t ldst_mask;
        logic       ldst_is_unsigned;
        logic       st_en;
    } exec_ctrl_t;

    typedef struct packed {
        logic branch;
        logic jump;
        logic ecall;
        logic ebreak;
        logic mret;
    } redirect_t;

    localparam exec_ctrl_t exec_ctrl_default = '{
        alu_imm_select:   1'b1,
        alu_pc_select:    pc_sel_none,
        alu_mux1_select:  1'b0,
        alu_unit:         unit_adder,
        alu_func:         func_add,
        rf_w_en:          1'b0,
        rf_w_select:      wb_alu,
        ldst_mask:        mask_none,
        ldst_is_unsigned: 1'b0,
        st_en:            1'b0
    };

endpackage

//--- verilog/instr_decoder.sv
// ================================================
// Purely combinational, no funct7 check beyond the
// alt bit. Unknown and CSR words give the default
// control with no redirect flag
// ================================================

`timescale 1ns/1ps

module instr_decoder
(
    input  isa_pkg::instr_t      instr,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output ctrl_pkg::redirect_t  redirect
);

    isa_pkg::opcode_t  opcode;
    isa_pkg::funct3_t  funct3;
    isa_pkg::sys_imm_t sys_imm;
    logic              is_alt;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign sys_imm = instr[31:20];
    assign is_alt  = instr[isa_pkg::alt_bit];

    always_comb
    begin
        exec_ctrl = ctrl_pkg::exec_ctrl_default;
        redirect  = '0;

        case (opcode)
            isa_pkg::op_reg, isa_pkg::op_imm:
            begin
                exec_ctrl.rf_w_en        = 1'b1;                     // Write back ALU result
                exec_ctrl.alu_imm_select = (opcode == isa_pkg::op_imm);
                case (funct3)
                    isa_pkg::funct3_add:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_adder;
                        // ADDI has no SUB form, bit 30 is immediate there
                        exec_ctrl.alu_func = (is_alt && opcode == isa_pkg::op_reg) ?
                                             ctrl_pkg::func_sub : ctrl_pkg::func_add;
                    end
                    isa_pkg::funct3_sll:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_shift;
                        exec_ctrl.alu_func = ctrl_pkg::func_sll;
                    end
                    isa_pkg::funct3_srl:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_shift;
                        exec_ctrl.alu_func = is_alt ? ctrl_pkg::func_sra : ctrl_pkg::func_srl;
                    end
                    isa_pkg::funct3_slt:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_cmp;
                        exec_ctrl.alu_func = ctrl_pkg::func_slt;
                    end
                    isa_pkg::funct3_sltu:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_cmp;
                        exec_ctrl.alu_func = ctrl_pkg::func_sltu;
                    end
                    isa_pkg::funct3_xor:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_logic;
                        exec_ctrl.alu_func = ctrl_pkg::func_xor;
                    end
                    isa_pkg::funct3_or:
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_logic;
                        exec_ctrl.alu_func = ctrl_pkg::func_or;
                    end
                    default:                                         // AND
                    begin
                        exec_ctrl.alu_unit = ctrl_pkg::unit_logic;
                        exec_ctrl.alu_func = ctrl_pkg::func_and;
                    end
                endcase
            end
            isa_pkg::op_load:
            begin
                case (funct3)
                    isa_pkg::funct3_lb: exec_ctrl.ldst_mask = ctrl_pkg::mask_byte;
                    isa_pkg::funct3_lh: exec_ctrl.ldst_mask = ctrl_pkg::mask_half;
                    isa_pkg::funct3_lw: exec_ctrl.ldst_mask = ctrl_pkg::mask_word;
                    isa_pkg::funct3_lbu:
                    begin
                        exec_ctrl.ldst_mask        = ctrl_pkg::mask_byte;
                        exec_ctrl.ldst_is_unsigned = 1'b1;
                    end
                    isa_pkg::funct3_lhu:
                    begin
                        exec_ctrl.ldst_mask        = ctrl_pkg::mask_half;
                        exec_ctrl.ldst_is_unsigned = 1'b1;
                    end
                    default: exec_ctrl.ldst_mask = ctrl_pkg::mask_none;
                endcase
                if (exec_ctrl.ldst_mask != ctrl_pkg::mask_none)
                begin
                    exec_ctrl.rf_w_en     = 1'b1;
                    exec_ctrl.rf_w_select = ctrl_pkg::wb_mem;
                end
            end
            isa_pkg::op_store:
            begin
                case (funct3)
                    isa_pkg::funct3_sb: exec_ctrl.ldst_mask = ctrl_pkg::mask_byte;
                    isa_pkg::funct3_sh: exec_ctrl.ldst_mask = ctrl_pkg::mask_half;
                    isa_pkg::funct3_sw: exec_ctrl.ldst_mask = ctrl_pkg::mask_word;
                    default: exec_ctrl.ldst_mask = ctrl_pkg::mask_none;
                endcase
                exec_ctrl.st_en = (exec_ctrl.ldst_mask != ctrl_pkg::mask_none);
            end
            isa_pkg::op_branch:
            begin
                redirect.branch = 1'b1;
                case (funct3)
                    isa_pkg::funct3_beq:  exec_ctrl.alu_func = ctrl_pkg::func_beq;
                    isa_pkg::funct3_bne:  exec_ctrl.alu_func = ctrl_pkg::func_bne;
                    isa_pkg::funct3_blt:  exec_ctrl.alu_func = ctrl_pkg::func_blt;
                    isa_pkg::funct3_bge:  exec_ctrl.alu_func = ctrl_pkg::func_bge;
                    isa_pkg::funct3_bltu: exec_ctrl.alu_func = ctrl_pkg::func_bltu;
                    isa_pkg::funct3_bgeu: exec_ctrl.alu_func = ctrl_pkg::func_bgeu;
                    default: redirect.branch = 1'b0;                 // funct3 010, 011
                endcase
                if (redirect.branch)
                begin
                    exec_ctrl.alu_pc_select   = ctrl_pkg::pc_sel_pc;   // Target is PC + imm
                    exec_ctrl.alu_mux1_select = 1'b1;
                end
            end
            isa_pkg::op_jal, isa_pkg::op_jalr:
            begin
                redirect.jump         = 1'b1;
                exec_ctrl.rf_w_en     = 1'b1;
                exec_ctrl.rf_w_select = ctrl_pkg::wb_ret;
                if (opcode == isa_pkg::op_jal)
                begin
                    exec_ctrl.alu_pc_select = ctrl_pkg::pc_sel_pc;
                end
            end
            isa_pkg::op_lui:
            begin
                exec_ctrl.alu_pc_select = ctrl_pkg::pc_sel_zero;     // 0 + imm
                exec_ctrl.rf_w_en       = 1'b1;
            end
            isa_pkg::op_auipc:
            begin
                exec_ctrl.alu_pc_select = ctrl_pkg::pc_sel_pc;
                exec_ctrl.rf_w_en       = 1'b1;
            end
            isa_pkg::op_system:
            begin
                if (funct3 == isa_pkg::funct3_priv)
                begin
                    redirect.ecall  = (sys_imm == isa_pkg::imm_ecall);
                    redirect.ebreak = (sys_imm == isa_pkg::imm_ebreak);
                    redirect.mret   = (sys_imm == isa_pkg::imm_mret);
                end
            end
            default: ;   // FENCE, FENCE.I act as NOP here
        endcase
    end

endmodule

//--- verilog/redirect_tracker.sv
// ================================================
// Flags reach execute two cycles after decode. A
// taken redirect or misalignment gives two bubble
// cycles; new causes are ignored during a flush
// ================================================

`timescale 1ns/1ps

module redirect_tracker
(
    input  logic                clk,
    input  logic                rst,
    input  ctrl_pkg::redirect_t redirect,
    input  logic                branch_true,
    input  logic                is_misaligned,
    output logic                make_nop
);

    ctrl_pkg::redirect_t redirect_id;
    ctrl_pkg::redirect_t redirect_ex;
    logic                flush_first;
    logic                flush_second;
    logic                take;

    // Execute stage decides on a redirect
    assign take = ((redirect_ex.branch && branch_true) ||
                   redirect_ex.jump || redirect_ex.ecall ||
                   redirect_ex.ebreak || redirect_ex.mret ||
                   is_misaligned) && !make_nop;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            redirect_id  <= '0;
            redirect_ex  <= '0;
            flush_first  <= 1'b0;
            flush_second <= 1'b0;
        end
        else
        begin
            redirect_id  <= redirect;
            redirect_ex  <= redirect_id;
            flush_first  <= take;
            flush_second <= take || flush_first;   // Stretch to two cycles
        end
    end

    assign make_nop = flush_second;

endmodule

//--- verilog/control_unit.sv
// ================================================
// One instruction per cycle, no back-pressure.
// redirect shows the decode-stage flags
// ================================================

`timescale 1ns/1ps

module control_unit
(
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::instr_t      instr,
    input  logic                 is_misaligned,
    input  logic                 branch_true,
    output logic                 fetch_instr,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output ctrl_pkg::redirect_t  redirect,
    output logic                 make_nop
);

    instr_decoder decoder_i
    (
        .instr     (instr),
        .exec_ctrl (exec_ctrl),
        .redirect  (redirect)
    );

    redirect_tracker tracker_i
    (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .branch_true   (branch_true),
        .is_misaligned (is_misaligned),
        .make_nop      (make_nop)
    );

    assign fetch_instr = ~rst;   // Fetch runs whenever out of reset

endmodule

//--- verification/tb_clk_gen.sv
// ==================================================
// Free-running 10 ns clock. rst is high from time 0
// and drops on the 10th rising edge
// ==================================================

`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic rst
);

    localparam int reset_cycles = 10;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verification/control_unit_assert.sv
// ==================================================
// Bound into control_unit. Covers flush length,
// one-hot decode flags, store control and reset exit
// ==================================================

`timescale 1ns/1ps

module control_unit_assert
(
    input logic                 clk,
    input logic                 rst,
    input ctrl_pkg::exec_ctrl_t exec_ctrl,
    input ctrl_pkg::redirect_t  redirect,
    input logic                 make_nop
);

    int flush_errors  = 0;
    int onehot_errors = 0;
    int store_errors  = 0;
    int reset_errors  = 0;

    flush_max_two: assert property (@(posedge clk) disable iff (rst)
        !(make_nop && $past(make_nop) && $past(make_nop, 2)))
    else
    begin
        flush_errors = flush_errors + 1;
        $error("make_nop high for three cycles in a row");
    end

    flags_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(redirect))
    else
    begin
        onehot_errors = onehot_errors + 1;
        $error("more than one decode redirect flag set");
    end

    store_no_write: assert property (@(posedge clk) disable iff (rst)
        exec_ctrl.st_en |-> !exec_ctrl.rf_w_en)
    else
    begin
        store_errors = store_errors + 1;
        $error("store decoded with register write enabled");
    end

    // First cycle out of reset starts with no bubble
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !make_nop)
    else
    begin
        reset_errors = reset_errors + 1;
        $error("make_nop high right after reset");
    end

endmodule

bind control_unit control_unit_assert assert_i
(
    .clk       (clk),
    .rst       (rst),
    .exec_ctrl (exec_ctrl),
    .redirect  (redirect),
    .make_nop  (make_nop)
);

//--- verification/control_unit_tb.sv
// ==================================================
// Directed tests of control_unit. Register and
// immediate fields come from an LCG with fixed seed
// ==================================================

`timescale 1ns/1ps

module control_unit_tb;

    localparam int test_cycles = 400;                 // Rough length of all tests
    localparam int max_cycles  = 5 * test_cycles;

    // ADDI x0, x0, 0
    localparam isa_pkg::instr_t nop_word =
        {12'd0, 5'd0, isa_pkg::funct3_add, 5'd0, isa_pkg::op_imm};

    localparam ctrl_pkg::redirect_t no_flags    = '0;
    localparam ctrl_pkg::redirect_t flag_branch = '{branch: 1'b1, default: 1'b0};
    localparam ctrl_pkg::redirect_t flag_jump   = '{jump: 1'b1, default: 1'b0};
    localparam ctrl_pkg::redirect_t flag_ecall  = '{ecall: 1'b1, default: 1'b0};
    localparam ctrl_pkg::redirect_t flag_ebreak = '{ebreak: 1'b1, default: 1'b0};
    localparam ctrl_pkg::redirect_t flag_mret   = '{mret: 1'b1, default: 1'b0};

    logic                 clk;
    logic                 rst;
    isa_pkg::instr_t      instr;
    logic                 is_misaligned;
    logic                 branch_true;
    logic                 fetch_instr;
    ctrl_pkg::exec_ctrl_t exec_ctrl;
    ctrl_pkg::redirect_t  redirect;
    logic                 make_nop;

    logic [31:0] lcg_state   = 32'h5f4c83e8;
    int          cycle_count = 0;

    tb_clk_gen clk_gen_i
    (
        .clk (clk),
        .rst (rst)
    );

    control_unit dut_i
    (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .is_misaligned (is_misaligned),
        .branch_true   (branch_true),
        .fetch_instr   (fetch_instr),
        .exec_ctrl     (exec_ctrl),
        .redirect      (redirect),
        .make_nop      (make_nop)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("Timeout, the tests did not finish within %0d cycles", max_cycles);
            $display("CHECKS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random fields around a fixed opcode and funct3
    function automatic isa_pkg::instr_t build_word(isa_pkg::opcode_t opcode,
                                                   isa_pkg::funct3_t funct3);
        isa_pkg::instr_t w;
        w        = lcg_next();
        w[14:12] = funct3;
        w[6:0]   = opcode;
        return w;
    endfunction

    function automatic isa_pkg::instr_t system_word(isa_pkg::sys_imm_t imm);
        return {imm, 5'd0, isa_pkg::funct3_priv, 5'd0, isa_pkg::op_system};
    endfunction

    function automatic ctrl_pkg::exec_ctrl_t writes_reg(ctrl_pkg::wb_sel_t sel);
        ctrl_pkg::exec_ctrl_t e;
        e             = ctrl_pkg::exec_ctrl_default;
        e.rf_w_en     = 1'b1;
        e.rf_w_select = sel;
        return e;
    endfunction

    function automatic ctrl_pkg::exec_ctrl_t alu_expect(isa_pkg::funct3_t funct3, logic alt,
                                                        logic is_reg);
        ctrl_pkg::exec_ctrl_t e;
        logic [5:0]           pair;                   // Unit and function
        case (funct3)
            isa_pkg::funct3_add:  pair = (alt && is_reg) ? {ctrl_pkg::unit_adder, 4'b1000} :
                                                           {ctrl_pkg::unit_adder, 4'b0000};
            isa_pkg::funct3_sll:  pair = {ctrl_pkg::unit_shift, 4'b0011};
            isa_pkg::funct3_slt:  pair = {ctrl_pkg::unit_cmp, 4'b0011};
            isa_pkg::funct3_sltu: pair = {ctrl_pkg::unit_cmp, 4'b0111};
            isa_pkg::funct3_xor:  pair = {ctrl_pkg::unit_logic, 4'b0100};
            isa_pkg::funct3_srl:  pair = alt ? {ctrl_pkg::unit_shift, 4'b0111} :
                                               {ctrl_pkg::unit_shift, 4'b0001};
            isa_pkg::funct3_or:   pair = {ctrl_pkg::unit_logic, 4'b0110};
            default:              pair = {ctrl_pkg::unit_logic, 4'b0111};
        endcase
        e                = writes_reg(ctrl_pkg::wb_alu);
        e.alu_imm_select = !is_reg;
        e.alu_unit       = ctrl_pkg::alu_unit_t'(pair[5:4]);
        e.alu_func       = pair[3:0];
        return e;
    endfunction

    task automatic check_exec(ctrl_pkg::exec_ctrl_t got, ctrl_pkg::exec_ctrl_t exp,
                              string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s exec_ctrl %h, expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_redirect(ctrl_pkg::redirect_t got, ctrl_pkg::redirect_t exp,
                                  string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s redirect %b, expected %b", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // New inputs on the rising edge, outputs read on the falling edge
    task automatic drive_cycle(isa_pkg::instr_t word, logic taken, logic misaligned);
        @(posedge clk);
        instr         <= word;
        branch_true   <= taken;
        is_misaligned <= misaligned;
        @(negedge clk);
    endtask

    task automatic decode_and_check(isa_pkg::instr_t word, ctrl_pkg::exec_ctrl_t exp_exec,
                                    ctrl_pkg::redirect_t exp_flags, string what);
        drive_cycle(word, 1'b0, 1'b0);
        check_exec(exec_ctrl, exp_exec, what);
        check_redirect(redirect, exp_flags, what);
    endtask

    task automatic nop_cycle(logic taken, logic misaligned, logic exp_nop, string what);
        drive_cycle(nop_word, taken, misaligned);
        check_bit(make_nop, exp_nop, what);
    endtask

    // Decode in n, execute in n+2, bubbles in n+3 and n+4
    task automatic redirect_sequence(isa_pkg::instr_t word, ctrl_pkg::exec_ctrl_t exp_exec,
                                     ctrl_pkg::redirect_t exp_flags, logic taken,
                                     logic flush, string what);
        decode_and_check(word, exp_exec, exp_flags, what);
        check_bit(make_nop, 1'b0, {what, " make_nop at decode"});
        nop_cycle(1'b0, 1'b0, 1'b0, {what, " make_nop in id"});
        nop_cycle(taken, 1'b0, 1'b0, {what, " make_nop in ex"});
        nop_cycle(1'b0, 1'b0, flush, {what, " first bubble"});
        nop_cycle(1'b0, 1'b0, flush, {what, " second bubble"});
        nop_cycle(1'b0, 1'b0, 1'b0, {what, " after flush"});
    endtask

    task automatic reset_behavior();
        repeat (3)
        begin
            @(negedge clk);
            check_bit(fetch_instr, 1'b0, "fetch_instr in reset");
            check_bit(make_nop, 1'b0, "make_nop in reset");
        end
        while (rst)
        begin
            @(negedge clk);
        end
        check_bit(fetch_instr, 1'b1, "fetch_instr after reset");
        repeat (5)
        begin
            nop_cycle(1'b0, 1'b0, 1'b0, "make_nop on NOP");
            check_bit(fetch_instr, 1'b1, "fetch_instr on NOP");
        end
    endtask

    task automatic alu_decode();
        isa_pkg::instr_t w;
        for (int f = 0; f < 8; f++)
        begin
            w       = build_word(isa_pkg::op_reg, 3'(f));
            w[31:25] = 7'd0;
            decode_and_check(w, alu_expect(3'(f), 1'b0, 1'b1), no_flags,
                             $sformatf("register ALU funct3 %0d", f));
            w = build_word(isa_pkg::op_imm, 3'(f));
            w[isa_pkg::alt_bit] = 1'b0;
            decode_and_check(w, alu_expect(3'(f), 1'b0, 1'b0), no_flags,
                             $sformatf("immediate ALU funct3 %0d", f));
        end
        w        = build_word(isa_pkg::op_reg, isa_pkg::funct3_add);
        w[31:25] = 7'b0100000;
        decode_and_check(w, alu_expect(isa_pkg::funct3_add, 1'b1, 1'b1), no_flags, "SUB");
        w        = build_word(isa_pkg::op_reg, isa_pkg::funct3_srl);
        w[31:25] = 7'b0100000;
        decode_and_check(w, alu_expect(isa_pkg::funct3_srl, 1'b1, 1'b1), no_flags, "SRA");
        w        = build_word(isa_pkg::op_imm, isa_pkg::funct3_srl);
        w[31:25] = 7'b0100000;
        decode_and_check(w, alu_expect(isa_pkg::funct3_srl, 1'b1, 1'b0), no_flags, "SRAI");
        // Bit 30 of an ADDI is part of the immediate
        w                   = build_word(isa_pkg::op_imm, isa_pkg::funct3_add);
        w[isa_pkg::alt_bit] = 1'b1;
        decode_and_check(w, alu_expect(isa_pkg::funct3_add, 1'b1, 1'b0), no_flags,
                         "ADDI with bit 30 set");
    endtask

    task automatic load_case(isa_pkg::funct3_t funct3, ctrl_pkg::byte_mask_t mask,
                             logic is_unsigned, string what);
        ctrl_pkg::exec_ctrl_t e;
        e                  = writes_reg(ctrl_pkg::wb_mem);
        e.ldst_mask        = mask;
        e.ldst_is_unsigned = is_unsigned;
        decode_and_check(build_word(isa_pkg::op_load, funct3), e, no_flags, what);
    endtask

    task automatic store_case(isa_pkg::funct3_t funct3, ctrl_pkg::byte_mask_t mask,
                              string what);
        ctrl_pkg::exec_ctrl_t e;
        e           = ctrl_pkg::exec_ctrl_default;
        e.ldst_mask = mask;
        e.st_en     = 1'b1;
        decode_and_check(build_word(isa_pkg::op_store, funct3), e, no_flags, what);
    endtask

    task automatic memory_and_misc_decode();
        ctrl_pkg::exec_ctrl_t e;
        load_case(isa_pkg::funct3_lb, ctrl_pkg::mask_byte, 1'b0, "LB");
        load_case(isa_pkg::funct3_lh, ctrl_pkg::mask_half, 1'b0, "LH");
        load_case(isa_pkg::funct3_lw, ctrl_pkg::mask_word, 1'b0, "LW");
        load_case(isa_pkg::funct3_lbu, ctrl_pkg::mask_byte, 1'b1, "LBU");
        load_case(isa_pkg::funct3_lhu, ctrl_pkg::mask_half, 1'b1, "LHU");
        store_case(isa_pkg::funct3_sb, ctrl_pkg::mask_byte, "SB");
        store_case(isa_pkg::funct3_sh, ctrl_pkg::mask_half, "SH");
        store_case(isa_pkg::funct3_sw, ctrl_pkg::mask_word, "SW");
        e               = writes_reg(ctrl_pkg::wb_alu);
        e.alu_pc_select = ctrl_pkg::pc_sel_zero;
        decode_and_check(build_word(isa_pkg::op_lui, 3'b000), e, no_flags, "LUI");
        e.alu_pc_select = ctrl_pkg::pc_sel_pc;
        decode_and_check(build_word(isa_pkg::op_auipc, 3'b000), e, no_flags, "AUIPC");
        e = ctrl_pkg::exec_ctrl_default;
        decode_and_check(build_word(isa_pkg::op_fence, isa_pkg::funct3_fence), e, no_flags,
                         "FENCE");
        decode_and_check(build_word(isa_pkg::op_fence, isa_pkg::funct3_fence_i), e, no_flags,
                         "FENCE.I");
        decode_and_check(build_word(7'b1111111, 3'b000), e, no_flags, "unused opcode");
        for (int f = 1; f < 8; f++)                  // CSR and reserved SYSTEM words
        begin
            decode_and_check(build_word(isa_pkg::op_system, 3'(f)), e, no_flags,
                             $sformatf("SYSTEM funct3 %0d", f));
        end
    endtask

    task automatic branch_case(isa_pkg::funct3_t funct3, ctrl_pkg::alu_func_t func,
                               string what);
        ctrl_pkg::exec_ctrl_t e;
        isa_pkg::instr_t      w;
        e                 = ctrl_pkg::exec_ctrl_default;
        e.alu_pc_select   = ctrl_pkg::pc_sel_pc;
        e.alu_mux1_select = 1'b1;
        e.alu_func        = func;
        w                 = build_word(isa_pkg::op_branch, funct3);
        redirect_sequence(w, e, flag_branch, 1'b1, 1'b1, {what, " taken"});
        redirect_sequence(w, e, flag_branch, 1'b0, 1'b0, {what, " not taken"});
    endtask

    task automatic branch_flushes();
        branch_case(isa_pkg::funct3_beq, 4'b0000, "BEQ");
        branch_case(isa_pkg::funct3_bne, 4'b0001, "BNE");
        branch_case(isa_pkg::funct3_blt, 4'b0011, "BLT");
        branch_case(isa_pkg::funct3_bge, 4'b0010, "BGE");
        branch_case(isa_pkg::funct3_bltu, 4'b0111, "BLTU");
        branch_case(isa_pkg::funct3_bgeu, 4'b0110, "BGEU");
    endtask

    task automatic jump_and_trap_flushes();
        ctrl_pkg::exec_ctrl_t e;
        isa_pkg::instr_t      w;
        e = writes_reg(ctrl_pkg::wb_ret);
        redirect_sequence(build_word(isa_pkg::op_jalr, 3'b000), e, flag_jump, 1'b0, 1'b1,
                          "JALR");
        e.alu_pc_select = ctrl_pkg::pc_sel_pc;
        w               = build_word(isa_pkg::op_jal, 3'b000);
        redirect_sequence(w, e, flag_jump, 1'b0, 1'b1, "JAL");
        redirect_sequence(system_word(isa_pkg::imm_ecall), ctrl_pkg::exec_ctrl_default,
                          flag_ecall, 1'b0, 1'b1, "ECALL");
        redirect_sequence(system_word(isa_pkg::imm_ebreak), ctrl_pkg::exec_ctrl_default,
                          flag_ebreak, 1'b0, 1'b1, "EBREAK");
        redirect_sequence(system_word(isa_pkg::imm_mret), ctrl_pkg::exec_ctrl_default,
                          flag_mret, 1'b0, 1'b1, "MRET");
        // Second JAL reaches execute during the flush of the first
        decode_and_check(w, e, flag_jump, "first JAL of pair");
        decode_and_check(w, e, flag_jump, "second JAL of pair");
        nop_cycle(1'b0, 1'b0, 1'b0, "JAL pair first in ex");
        nop_cycle(1'b0, 1'b0, 1'b1, "JAL pair first bubble");
        nop_cycle(1'b0, 1'b0, 1'b1, "JAL pair second bubble");
        nop_cycle(1'b0, 1'b0, 1'b0, "JAL pair after flush");
        nop_cycle(1'b0, 1'b0, 1'b0, "JAL pair no extra flush");
    endtask

    task automatic misaligned_flushes();
        nop_cycle(1'b0, 1'b1, 1'b0, "misaligned pulse cycle");
        nop_cycle(1'b0, 1'b0, 1'b1, "misaligned first bubble");
        nop_cycle(1'b0, 1'b0, 1'b1, "misaligned second bubble");
        nop_cycle(1'b0, 1'b0, 1'b0, "misaligned after flush");
        nop_cycle(1'b0, 1'b1, 1'b0, "misaligned pair first pulse");
        nop_cycle(1'b0, 1'b1, 1'b1, "misaligned pulse in flush");
        nop_cycle(1'b0, 1'b0, 1'b1, "misaligned pair second bubble");
        nop_cycle(1'b0, 1'b0, 1'b0, "misaligned pair after flush");
        nop_cycle(1'b0, 1'b0, 1'b0, "misaligned pair no extra flush");
    endtask

    initial
    begin
        int assert_fails;
        instr         = nop_word;
        branch_true   = 1'b0;
        is_misaligned = 1'b0;
        reset_behavior();
        alu_decode();
        memory_and_misc_decode();
        branch_flushes();
        jump_and_trap_flushes();
        misaligned_flushes();
        assert_fails = dut_i.assert_i.flush_errors + dut_i.assert_i.onehot_errors +
                       dut_i.assert_i.store_errors + dut_i.assert_i.reset_errors;
        if (assert_fails == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("Concurrent assertions failed %0d times", assert_fails);
            $display("CHECKS FAILED");
            $fatal(1, "Run ended with assertion failures");
        end
    end

endmodule

//--- project.f
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/redirect_tracker.sv
verilog/control_unit.sv
verification/tb_clk_gen.sv
verification/control_unit_assert.sv
verification/control_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = control_unit_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# The run may exit non-zero; the log search decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
